// ==== common/raster_defs.svh ====
// fixed-point formats, field widths and viewport constants of the raster front end
`ifndef RASTER_DEFS_SVH
`define RASTER_DEFS_SVH

`define FRAC_BITS    14    // camera vectors are q1.14
`define P_WIDTH      16    // signed vertex coordinate
`define C_WIDTH      18    // signed camera center
`define V_WIDTH      16    // camera basis vector component
`define ZWIDTH       16    // depth out of the projection

// viewport positions, signed
`define VX_WIDTH     18
`define VY_WIDTH     20

`define VW_OVER_TWO  320   // half viewport width
`define VH_OVER_TWO  240   // half viewport height

`define NUM_TRI      2048  // id is 11 bits
`define COLOR_WIDTH  16    // rgb565

`endif

// ==== common/geom_pkg.sv ====
// geometry types for vertices, camera pose and projected triangles
`include "raster_defs.svh"

package geom_pkg;

  typedef struct packed {
    logic signed [`P_WIDTH-1:0] x;
    logic signed [`P_WIDTH-1:0] y;
    logic signed [`P_WIDTH-1:0] z;
  } vec3_t;

  typedef struct packed {
    logic signed [`C_WIDTH-1:0] x;
    logic signed [`C_WIDTH-1:0] y;
    logic signed [`C_WIDTH-1:0] z;
  } cvec3_t;

  typedef struct packed {
    logic signed [`V_WIDTH-1:0] x;
    logic signed [`V_WIDTH-1:0] y;
    logic signed [`V_WIDTH-1:0] z;
  } nvec3_t;

  // camera center plus right, up and viewing axes
  typedef struct packed {
    cvec3_t c;
    nvec3_t u;
    nvec3_t v;
    nvec3_t n;
  } camera_t;

  typedef struct packed {
    logic [$clog2(`NUM_TRI)-1:0] id;
    vec3_t [2:0]                 vtx;  // vertex 0 in the low bits
    camera_t                     cam;
  } tri_in_t;

  typedef struct packed {
    logic signed [2:0][`VX_WIDTH-1:0] x;
    logic signed [2:0][`VY_WIDTH-1:0] y;
    logic        [2:0][`ZWIDTH-1:0]   z;
    logic        [`COLOR_WIDTH-1:0]   color;
  } screen_tri_t;

endpackage

// ==== common/ctrl_pkg.sv ====
// state encodings for the join FSM and the two processing unit sequencers
package ctrl_pkg;

  typedef enum logic [1:0] {
    IDLE,
    PROCESSING,
    HOLD
  } join_state_e;

  typedef enum logic [1:0] {
    U_IDLE,
    U_RUN,
    U_DONE  // results held until next start
  } unit_state_e;

endpackage

// ==== src/tri_in_buf.sv ====
// input skid buffer that registers triangles and soaks up one stalled beat
module tri_in_buf import geom_pkg::*; (
  input  logic    clk_in,
  input  logic    rst_in,
  input  logic    in_valid,
  input  tri_in_t in_tri,
  output logic    in_ready,
  output logic    buf_valid,
  output tri_in_t buf_tri,
  input  logic    join_ready
);

  logic    spill_valid;
  tri_in_t spill_tri;
  logic    take;
  logic    main_free;

  assign take      = in_valid && in_ready;
  assign main_free = !buf_valid || join_ready;
  assign in_ready  = !spill_valid;  // straight off a flop

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      buf_valid   <= 1'b0;
      spill_valid <= 1'b0;
    end else if (main_free) begin
      buf_valid   <= spill_valid || take;
      spill_valid <= 1'b0;
    end else if (take) begin
      spill_valid <= 1'b1;  // main stalled, park the beat
    end
  end

  // spill slot drains first so order is kept
  always_ff @(posedge clk_in) begin
    if (main_free) begin
      buf_tri <= spill_valid ? spill_tri : in_tri;
    end else if (take) begin
      spill_tri <= in_tri;
    end
  end

  // a beat held off at the input waits unchanged
  a_in_hold: assert property (@(posedge clk_in) disable iff (rst_in)
    in_valid && !in_ready |=> in_valid && $stable(in_tri));

endmodule

// ==== vertex_pre_proc/vertex_pre_proc.sv ====
// vertex unit that moves three vertices into camera space and onto the viewport
`include "raster_defs.svh"

module vertex_pre_proc import geom_pkg::*, ctrl_pkg::*; (
  input  logic                             clk_in,
  input  logic                             rst_in,
  input  logic                             start,
  input  tri_in_t                          tri_in,
  output logic                             done,
  output logic                             cull,
  output logic signed [2:0][`VX_WIDTH-1:0] x_pos,
  output logic signed [2:0][`VY_WIDTH-1:0] y_pos,
  output logic        [2:0][`ZWIDTH-1:0]   z_depth
);

  localparam int D_W   = `C_WIDTH + 1;        // P - C cannot overflow
  localparam int ACC_W = D_W + `V_WIDTH + 2;  // sum of three products
  localparam int XW    = `VX_WIDTH;
  localparam int YW    = `VY_WIDTH;
  localparam int ZW    = `ZWIDTH;

  unit_state_e                state;
  logic [1:0]                 vidx;
  logic                       mac_phase;  // 0 subtract, 1 dot products
  vec3_t                      p_sel;
  logic signed [2:0][D_W-1:0] d;
  logic signed [ACC_W-1:0]    acc_u;
  logic signed [ACC_W-1:0]    acc_v;
  logic signed [ACC_W-1:0]    acc_n;
  logic signed [XW-1:0]       pu;
  logic signed [YW-1:0]       pv;
  logic signed [ZW-1:0]       pn;

  function automatic logic signed [ACC_W-1:0] dot3(
    input logic signed [2:0][D_W-1:0] a,
    input nvec3_t                     b
  );
    return $signed(a[0]) * b.x + $signed(a[1]) * b.y + $signed(a[2]) * b.z;
  endfunction

  assign p_sel = start ? tri_in.vtx[0] : tri_in.vtx[vidx];

  // one dot-product lane per camera axis, reused for every vertex
  assign acc_u = dot3(d, tri_in.cam.u);
  assign acc_v = dot3(d, tri_in.cam.v);
  assign acc_n = dot3(d, tri_in.cam.n);

  // back to integer units, then cut to the field width
  assign pu = XW'(acc_u >>> `FRAC_BITS);
  assign pv = YW'(acc_v >>> `FRAC_BITS);
  assign pn = ZW'(acc_n >>> `FRAC_BITS);

  assign done = (state == U_DONE);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state     <= U_IDLE;
      vidx      <= 2'd0;
      mac_phase <= 1'b0;
      cull      <= 1'b0;
    end else if (start) begin
      state     <= U_RUN;
      vidx      <= 2'd0;
      mac_phase <= 1'b1;  // vertex 0 offset taken on this edge
      cull      <= 1'b0;
    end else if (state == U_RUN) begin
      mac_phase <= !mac_phase;
      if (mac_phase) begin
        cull <= cull || (pn <= 0);  // behind or on the camera plane
        if (vidx == 2'd2) begin
          state <= U_DONE;
        end else begin
          vidx <= vidx + 2'd1;
        end
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (start || (state == U_RUN && !mac_phase)) begin
      d[0] <= p_sel.x - tri_in.cam.c.x;
      d[1] <= p_sel.y - tri_in.cam.c.y;
      d[2] <= p_sel.z - tri_in.cam.c.z;
    end
    if (state == U_RUN && mac_phase) begin
      x_pos[vidx]   <= pu + XW'(`VW_OVER_TWO);
      y_pos[vidx]   <= pv + YW'(`VH_OVER_TWO);
      z_depth[vidx] <= pn;
    end
  end

  // the join must wait for done before restarting
  a_no_restart: assert property (@(posedge clk_in) disable iff (rst_in)
    start |-> state != U_RUN);

endmodule

// ==== shader/shader.sv ====
// flat shading unit that colors a triangle from its id and the camera normal
`include "raster_defs.svh"

module shader import geom_pkg::*, ctrl_pkg::*; (
  input  logic                        clk_in,
  input  logic                        rst_in,
  input  logic                        start,
  input  logic [$clog2(`NUM_TRI)-1:0] tri_id,
  input  nvec3_t                      cam_normal,
  output logic                        done,
  output logic                        cull,
  output logic [`COLOR_WIDTH-1:0]     color
);

  unit_state_e         state;
  logic [1:0]          chan;  // 0 red, 1 green, 2 blue
  logic [`V_WIDTH-1:0] nz_mag;
  logic [`V_WIDTH-1:0] nz_scaled;
  logic [3:0]          level;
  logic [3:0]          intensity;
  logic [5:0]          base;
  logic [9:0]          prod;
  logic [4:0]          red;
  logic [5:0]          green;
  logic [4:0]          blue;

  assign nz_mag    = (cam_normal.z < 0) ? -cam_normal.z : cam_normal.z;
  assign nz_scaled = nz_mag >> (`FRAC_BITS - 4);
  assign level     = (nz_scaled > 15) ? 4'd15 : nz_scaled[3:0];

  always_comb begin
    case (chan)
      2'd0:    base = {1'b0, tri_id[4:0]};
      2'd1:    base = tri_id[10:5];
      2'd2:    base = {1'b0, tri_id[10:6]};
      default: base = 6'd0;
    endcase
  end

  assign prod  = base * intensity;  // single shared multiplier
  assign done  = (state == U_DONE);
  assign color = {red, green, blue};

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= U_IDLE;
      chan  <= 2'd0;
      cull  <= 1'b0;
    end else if (start) begin
      state <= U_RUN;
      chan  <= 2'd0;
      cull  <= (level == 4'd0);  // dark, nothing to draw
    end else if (state == U_RUN) begin
      chan <= chan + 2'd1;
      if (chan == 2'd2) begin
        state <= U_DONE;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (start) begin
      intensity <= level;
    end
    if (state == U_RUN) begin
      case (chan)
        2'd0:    red   <= prod[8:4];
        2'd1:    green <= prod[9:4];
        2'd2:    blue  <= prod[8:4];
        default: ;
      endcase
    end
  end

endmodule

// ==== src/pre_proc_shader.sv ====
// join stage that runs the vertex and shading units side by side and merges them
`include "raster_defs.svh"

module pre_proc_shader import geom_pkg::*, ctrl_pkg::*; (
  input  logic        clk_in,
  input  logic        rst_in,
  input  logic        valid_in,
  input  tri_in_t     tri_in,
  output logic        ready_out,
  output logic        valid_out,
  output screen_tri_t tri_out,
  input  logic        ready_in
);

  join_state_e                      state;
  tri_in_t                          tri_q;
  logic                             start;
  logic                             vpp_done;
  logic                             vpp_cull;
  logic signed [2:0][`VX_WIDTH-1:0] vpp_x;
  logic signed [2:0][`VY_WIDTH-1:0] vpp_y;
  logic        [2:0][`ZWIDTH-1:0]   vpp_z;
  logic                             sh_done;
  logic                             sh_cull;
  logic [`COLOR_WIDTH-1:0]          sh_color;
  logic                             vpp_seen;
  logic                             sh_seen;
  logic                             vpp_hit;
  logic                             sh_hit;
  logic                             both_done;

  vertex_pre_proc vertex_pre_proc_inst (
    .clk_in  (clk_in),
    .rst_in  (rst_in),
    .start   (start),
    .tri_in  (tri_q),
    .done    (vpp_done),
    .cull    (vpp_cull),
    .x_pos   (vpp_x),
    .y_pos   (vpp_y),
    .z_depth (vpp_z)
  );

  shader shader_inst (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .start      (start),
    .tri_id     (tri_q.id),
    .cam_normal (tri_q.cam.n),
    .done       (sh_done),
    .cull       (sh_cull),
    .color      (sh_color)
  );

  assign ready_out = (state == IDLE);

  // done is stale from the last triangle while start is high
  assign vpp_hit   = (state == PROCESSING) && !start && vpp_done && !vpp_seen;
  assign sh_hit    = (state == PROCESSING) && !start && sh_done && !sh_seen;
  assign both_done = (state == PROCESSING) && !start &&
                     (vpp_done || vpp_seen) && (sh_done || sh_seen);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state     <= IDLE;
      start     <= 1'b0;
      valid_out <= 1'b0;
      vpp_seen  <= 1'b0;
      sh_seen   <= 1'b0;
    end else begin
      start <= 1'b0;
      if (vpp_hit) begin
        vpp_seen <= 1'b1;
      end
      if (sh_hit) begin
        sh_seen <= 1'b1;
      end
      case (state)
        IDLE: begin
          if (valid_in) begin
            state    <= PROCESSING;
            start    <= 1'b1;
            vpp_seen <= 1'b0;
            sh_seen  <= 1'b0;
          end
        end
        PROCESSING: begin
          if (both_done) begin
            if (vpp_cull || sh_cull) begin
              state <= IDLE;  // culled, never handed out
            end else begin
              valid_out <= 1'b1;
              state     <= HOLD;
            end
          end
        end
        HOLD: begin
          if (ready_in) begin
            valid_out <= 1'b0;
            state     <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (valid_in && ready_out) begin
      tri_q <= tri_in;
    end
    if (vpp_hit) begin
      tri_out.x <= vpp_x;
      tri_out.y <= vpp_y;
      tri_out.z <= vpp_z;
    end
    if (sh_hit) begin
      tri_out.color <= sh_color;
    end
  end

  // a waiting triangle stays offered and unchanged while the join is busy
  a_in_hold: assert property (@(posedge clk_in) disable iff (rst_in)
    valid_in && !ready_out |=> valid_in && $stable(tri_in));

endmodule

// ==== src/tri_out_fifo.sv ====
// output queue of screen triangles on their way to the rasterizer
module tri_out_fifo import geom_pkg::*; #(
  parameter int DEPTH = 2
) (
  input  logic        clk_in,
  input  logic        rst_in,
  input  logic        wr_valid,
  input  screen_tri_t wr_tri,
  output logic        wr_ready,
  output logic        rd_valid,
  output screen_tri_t rd_tri,
  input  logic        rd_ready
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  screen_tri_t   mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          push;
  logic          pop;

  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign wr_ready = (count != CW'(DEPTH));  // not full
  assign rd_valid = (count != '0);
  assign rd_tri   = mem[rd_ptr];
  assign push     = wr_valid && wr_ready;
  assign pop      = rd_valid && rd_ready;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (push) begin
      mem[wr_ptr] <= wr_tri;
    end
  end

  // a write refused while full waits unchanged for room
  a_no_overwrite: assert property (@(posedge clk_in) disable iff (rst_in)
    wr_valid && !wr_ready |=> wr_valid && $stable(wr_tri));

endmodule

// ==== src/raster_front.sv ====
// raster front end top with input buffer, projection and shading join, output queue
module raster_front import geom_pkg::*; (
  input  logic        clk_in,
  input  logic        rst_in,
  input  logic        in_valid,
  input  tri_in_t     in_tri,
  output logic        in_ready,
  output logic        out_valid,
  output screen_tri_t out_tri,
  input  logic        out_ready
);

  logic        buf_valid;
  tri_in_t     buf_tri;
  logic        join_ready;
  logic        proc_valid;
  screen_tri_t proc_tri;
  logic        fifo_ready;

  tri_in_buf tri_in_buf_inst (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .in_valid   (in_valid),
    .in_tri     (in_tri),
    .in_ready   (in_ready),
    .buf_valid  (buf_valid),
    .buf_tri    (buf_tri),
    .join_ready (join_ready)
  );

  pre_proc_shader pre_proc_shader_inst (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .valid_in  (buf_valid),
    .tri_in    (buf_tri),
    .ready_out (join_ready),
    .valid_out (proc_valid),
    .tri_out   (proc_tri),
    .ready_in  (fifo_ready)
  );

  tri_out_fifo #(
    .DEPTH (2)
  ) tri_out_fifo_inst (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .wr_valid (proc_valid),
    .wr_tri   (proc_tri),
    .wr_ready (fifo_ready),
    .rd_valid (out_valid),
    .rd_tri   (out_tri),
    .rd_ready (out_ready)
  );

endmodule

// ==== bench/tb_raster_front.sv ====
// testbench for the raster front end with random triangles checked against a reference model
`include "raster_defs.svh"

module tb_raster_front import geom_pkg::*; ();

  localparam int NUM_PER_TEST = 200;
  localparam int CYCLE_LIMIT  = 40 * 3 * NUM_PER_TEST + 200;  // three issuing tests

  logic        clk_in;
  logic        rst_in;
  logic        in_valid;
  tri_in_t     in_tri;
  logic        in_ready;
  logic        out_valid;
  screen_tri_t out_tri;
  logic        out_ready;

  screen_tri_t exp_q[$];
  screen_tri_t exp_t;
  screen_tri_t held_tri;
  logic        held;
  logic        stall_mode;
  int          errors = 0;
  int          checks = 0;
  int          outputs = 0;
  int          tests = 0;
  int          cycle_count = 0;

  raster_front i_dut (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .in_valid  (in_valid),
    .in_tri    (in_tri),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_tri   (out_tri),
    .out_ready (out_ready)
  );

  always #4 clk_in = !clk_in;

  task automatic check_equal(input string what, input logic [191:0] got,
                             input logic [191:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic int rand_span(input int span);
    return int'($urandom % 32'(2 * span + 1)) - span;
  endfunction

  // projection and flat shading straight from the rules
  function automatic void model(input tri_in_t t, output screen_tri_t s, output logic culled);
    longint dx;
    longint dy;
    longint dz;
    longint dot_u;
    longint dot_v;
    longint dot_n;
    logic signed [`ZWIDTH-1:0] pn;
    int mag;
    int lvl;
    culled = 1'b0;
    for (int k = 0; k < 3; k++) begin
      dx = longint'(t.vtx[k].x) - longint'(t.cam.c.x);
      dy = longint'(t.vtx[k].y) - longint'(t.cam.c.y);
      dz = longint'(t.vtx[k].z) - longint'(t.cam.c.z);
      dot_u = dx * longint'(t.cam.u.x) + dy * longint'(t.cam.u.y) + dz * longint'(t.cam.u.z);
      dot_v = dx * longint'(t.cam.v.x) + dy * longint'(t.cam.v.y) + dz * longint'(t.cam.v.z);
      dot_n = dx * longint'(t.cam.n.x) + dy * longint'(t.cam.n.y) + dz * longint'(t.cam.n.z);
      s.x[k] = `VX_WIDTH'((dot_u >>> `FRAC_BITS) + `VW_OVER_TWO);
      s.y[k] = `VY_WIDTH'((dot_v >>> `FRAC_BITS) + `VH_OVER_TWO);
      pn = `ZWIDTH'(dot_n >>> `FRAC_BITS);
      s.z[k] = pn;
      culled = culled || pn[`ZWIDTH-1] || (pn == '0);  // behind the camera
    end
    mag = t.cam.n.z[`V_WIDTH-1] ? -int'(t.cam.n.z) : int'(t.cam.n.z);
    lvl = mag >> (`FRAC_BITS - 4);
    if (lvl > 15) begin
      lvl = 15;
    end
    s.color = {5'((int'(t.id[4:0]) * lvl) >> 4), 6'((int'(t.id[10:5]) * lvl) >> 4),
               5'((int'(t.id[10:6]) * lvl) >> 4)};
    culled = culled || (lvl == 0);
  endfunction

  function automatic tri_in_t make_tri(input logic visible_only);
    tri_in_t t;
    int      side;
    int      dz;
    logic    behind;
    side   = ($urandom % 2 == 0) ? 1 : -1;  // which way the camera looks along z
    behind = !visible_only && ($urandom % 4 == 0);
    t.id      = 11'($urandom);
    t.cam.c.x = `C_WIDTH'(rand_span(2000));
    t.cam.c.y = `C_WIDTH'(rand_span(2000));
    t.cam.c.z = `C_WIDTH'(rand_span(2000));
    t.cam.u.x = `V_WIDTH'(15000 + rand_span(1000));
    t.cam.u.y = `V_WIDTH'(rand_span(2048));
    t.cam.u.z = `V_WIDTH'(rand_span(2048));
    t.cam.v.x = `V_WIDTH'(rand_span(2048));
    t.cam.v.y = `V_WIDTH'(15000 + rand_span(1000));
    t.cam.v.z = `V_WIDTH'(rand_span(2048));
    t.cam.n.x = `V_WIDTH'(rand_span(256));
    t.cam.n.y = `V_WIDTH'(rand_span(256));
    // reaches a little past 1.0 so the intensity clamp is hit too
    t.cam.n.z = `V_WIDTH'(side * (1024 + int'($urandom % 16384)));
    if (!visible_only && $urandom % 8 == 0) begin
      t.cam.n.z = '0;  // dark triangle
    end
    for (int k = 0; k < 3; k++) begin
      dz = side * (400 + int'($urandom % 1000));
      if (behind && k == 2) begin
        dz = -dz;  // last vertex goes behind the camera
      end
      t.vtx[k].x = `P_WIDTH'(int'(t.cam.c.x) + rand_span(500));
      t.vtx[k].y = `P_WIDTH'(int'(t.cam.c.y) + rand_span(500));
      t.vtx[k].z = `P_WIDTH'(int'(t.cam.c.z) + dz);
    end
    return t;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk_in);
      #1;
    end
  endtask

  task automatic send_tri(input tri_in_t t);
    screen_tri_t s;
    logic        culled;
    logic        taken;
    model(t, s, culled);
    if (!culled) begin
      exp_q.push_back(s);
    end
    in_tri   = t;
    in_valid = 1'b1;
    taken    = 1'b0;
    while (!taken) begin
      @(negedge clk_in);
      taken = in_ready;
      @(posedge clk_in);
      #1;
    end
    in_valid = 1'b0;
  endtask

  task automatic report_test(input string name, input int err0);
    tests++;
    $display("test %s finished with %0d errors", name, errors - err0);
  endtask

  task automatic run_batch(input string name, input logic visible_only, input logic bursty);
    int err0;
    int gap;
    err0 = errors;
    for (int i = 0; i < NUM_PER_TEST; i++) begin
      send_tri(make_tri(visible_only));
      gap = bursty ? (($urandom % 8 == 0) ? 6 : 0) : int'($urandom % 3);
      wait_cycles(gap);
    end
    while (exp_q.size() != 0) begin
      wait_cycles(1);
    end
    wait_cycles(40);  // culled stragglers must stay invisible
    report_test(name, err0);
  endtask

  // out_ready changes just after the edge, like every other input
  always @(posedge clk_in) begin
    #1;
    out_ready = stall_mode ? 1'($urandom % 2) : 1'b1;
  end

  // scoreboard, sampled mid-cycle where everything is settled
  always @(negedge clk_in) begin
    if (rst_in) begin
      held = 1'b0;
    end else begin
      if (held) begin
        check_equal("out_valid while stalled", 192'(out_valid), 192'(1));
        check_equal("out_tri while stalled", 192'(out_tri), 192'(held_tri));
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("a triangle came out at %0t that the model culled or never sent", $time);
        end else begin
          exp_t = exp_q.pop_front();
          outputs++;
          check_equal("x", 192'(out_tri.x), 192'(exp_t.x));
          check_equal("y", 192'(out_tri.y), 192'(exp_t.y));
          check_equal("z", 192'(out_tri.z), 192'(exp_t.z));
          check_equal("color", 192'(out_tri.color), 192'(exp_t.color));
        end
      end
      held     = out_valid && !out_ready;
      held_tri = out_tri;
    end
  end

  always @(posedge clk_in) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the run did not finish", cycle_count);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    int err0;
    void'($urandom(32'he41b));
    clk_in     = 1'b0;
    rst_in     = 1'b1;
    in_valid   = 1'b0;
    in_tri     = '0;
    out_ready  = 1'b0;
    stall_mode = 1'b0;
    held       = 1'b0;
    repeat (16) @(posedge clk_in);
    #1;
    rst_in = 1'b0;

    err0 = errors;
    @(negedge clk_in);
    check_equal("in_ready after reset", 192'(in_ready), 192'(1));
    check_equal("out_valid after reset", 192'(out_valid), 192'(0));
    @(posedge clk_in);
    #1;
    report_test("reset", err0);

    run_batch("projection and shading", 1'b1, 1'b0);
    run_batch("culling", 1'b0, 1'b0);
    stall_mode = 1'b1;
    run_batch("back-pressure", 1'b0, 1'b1);
    stall_mode = 1'b0;

    $display("tests %0d, checks %0d, triangles out %0d, errors %0d",
             tests, checks, outputs, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+common
common/geom_pkg.sv
common/ctrl_pkg.sv
src/tri_in_buf.sv
vertex_pre_proc/vertex_pre_proc.sv
shader/shader.sv
src/pre_proc_shader.sv
src/tri_out_fifo.sv
src/raster_front.sv
bench/tb_raster_front.sv

// ==== Makefile ====
SIM = obj_dir/Vtb_raster_front

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f all.f --top-module tb_raster_front -Mdir obj_dir
	@out=$$(./$(SIM)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
